// File: src.f
source/gf_pkg.sv
source/cipher_pkg.sv
source/sbox6.sv
source/round_datapath.sv
source/key_schedule.sv
source/cipher_core.sv
dv/cipher_checker.sv
dv/tb_cipher.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_cipher -f src.f
	./obj_dir/Vtb_cipher | tee sim.log
	@! grep -q "Finished with errors" sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_cipher.sv
module tb_cipher
  import cipher_pkg::*;
();

  localparam int rounds = 6;

  logic   clk;
  logic   arst_n;
  logic   start;
  block_t plaintext;
  key_t   key;
  block_t ciphertext;
  logic   busy;
  logic   done;
  int     errors;
  int     results;
  int     drive_errors;
  int     limit_cycles;
  int     seed;

  block_t pt_q[$];
  key_t   key_q[$];
  int     gap_q[$];
  logic   extra_q[$];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  cipher_core #(
    .rounds (rounds)
  ) u_cipher_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .busy       (busy),
    .done       (done)
  );

  cipher_checker #(
    .rounds (rounds)
  ) u_cipher_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .busy       (busy),
    .done       (done),
    .errors     (errors),
    .results    (results)
  );

  task automatic add_entry(block_t pt, key_t k, int gap, logic extra);
    pt_q.push_back(pt);
    key_q.push_back(k);
    gap_q.push_back(gap);
    extra_q.push_back(extra);
  endtask

  task automatic build_table();
    block_t pt;
    key_t   k;
    add_entry(24'h000000, 24'h000000, 5, 1'b0);  // Idle first
    add_entry(24'hffffff, 24'hffffff, 0, 1'b0);
    add_entry(24'h041041, 24'h000000, 0, 1'b1);  // One bit per lane
    add_entry(24'h820820, 24'h5a5a5a, 2, 1'b1);
    for (int i = 0; i < 64; i++) begin
      add_entry(24'(i), 24'h000000, i % 2, 1'b0);  // Lane 0 sweep
    end
    for (int i = 0; i < 16; i++) begin
      pt = 24'($random(seed));
      k  = 24'($random(seed));
      add_entry(pt, k, i % 3, i % 4 == 1);
    end
  endtask

  task automatic run_entry(int i);
    int waited;
    repeat (gap_q[i]) begin
      @(posedge clk);
      #1;
    end
    start     = 1'b1;
    plaintext = pt_q[i];
    key       = key_q[i];
    @(posedge clk);
    #1;
    start = 1'b0;
    if (extra_q[i]) begin
      @(posedge clk);
      #1;
      start     = 1'b1;        // Lands while busy
      plaintext = ~pt_q[i];
      key       = ~key_q[i];
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    waited = 0;
    while (done !== 1'b1 && waited < rounds + 8) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (done !== 1'b1) begin
      $display("done never came for table entry %0d", i);
      drive_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    int sum;
    seed         = 32'hdb04;
    arst_n       = 1'b0;
    start        = 1'b0;
    plaintext    = '0;
    key          = '0;
    drive_errors = 0;
    sum          = 100;
    build_table();
    foreach (gap_q[i]) begin
      sum += gap_q[i] + rounds + 4;
    end
    limit_cycles = sum;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    foreach (pt_q[i]) begin
      run_entry(i);
    end
    repeat (4) @(posedge clk);
    if (results != pt_q.size()) begin
      $display("only %0d of %0d blocks completed", results, pt_q.size());
      drive_errors++;
    end
    $display("blocks %0d, checker errors %0d, driver errors %0d",
             results, errors, drive_errors);
    if (errors + drive_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the run did not finish", limit_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: dv/cipher_checker.sv
module cipher_checker
  import gf_pkg::*;
  import cipher_pkg::*;
#(
  parameter int rounds = 6
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  block_t plaintext,
  input  key_t   key,
  input  block_t ciphertext,
  input  logic   busy,
  input  logic   done,
  output int     errors,
  output int     results
);

  int     cyc;
  int     start_at;
  int     done_at;
  logic   have_op;
  logic   exp_busy;
  logic   exp_done;
  block_t exp_ct;

  function automatic block_t spread_bits(block_t b);
    block_t r;
    for (int i = 0; i < 24; i++) begin
      r[6*(i%4) + i/4] = b[i];
    end
    return r;
  endfunction

  function automatic key_t update_key(key_t k, int idx);
    key_t r;
    r      = {k[17:0], k[23:18]};
    r[5:0] = sbox_ref(r[5:0]) ^ 6'(idx);
    return r;
  endfunction

  function automatic block_t model_encrypt(block_t pt, key_t k);
    block_t s;
    key_t   rk;
    s  = pt;
    rk = k;
    for (int r = 0; r < rounds; r++) begin
      s = s ^ rk;
      for (int l = 0; l < 4; l++) begin
        s[6*l +: 6] = sbox_ref(s[6*l +: 6]);
      end
      s  = spread_bits(s);
      rk = update_key(rk, r);    // Same step, old key used above
    end
    return s ^ rk;
  endfunction

  task automatic report_mismatch(string name, logic [23:0] got, logic [23:0] exp);
    $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
    errors++;
  endtask

  initial begin
    errors  = 0;
    results = 0;
    have_op = 1'b0;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // Sampled mid-cycle, away from both the edge and the driver
  always @(negedge clk) begin
    if (arst_n) begin
      exp_busy = have_op && (cyc >= start_at) && (cyc <= done_at);
      exp_done = have_op && (cyc == done_at);
      if (busy !== exp_busy) begin
        report_mismatch("busy", 24'(busy), 24'(exp_busy));
      end
      if (done !== exp_done) begin
        report_mismatch("done", 24'(done), 24'(exp_done));
      end
      if (exp_done && done === 1'b1) begin
        results++;
      end
      if (have_op && cyc >= done_at && ciphertext !== exp_ct) begin
        report_mismatch("ciphertext", ciphertext, exp_ct);
      end
      if (start === 1'b1 && !exp_busy) begin  // Taken at the next edge
        have_op  = 1'b1;
        start_at = cyc + 1;
        done_at  = cyc + rounds + 2;
        exp_ct   = model_encrypt(plaintext, key);
      end
    end
  end

endmodule

// File: source/cipher_core.sv
module cipher_core
  import cipher_pkg::*;
#(
  parameter int rounds = 6
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  block_t plaintext,
  input  key_t   key,
  output block_t ciphertext,
  output logic   busy,
  output logic   done
);

  core_state_e st;
  core_state_e st_nxt;
  logic [3:0]  cnt;
  logic        load;
  logic        step;
  logic        last;
  block_t      state;
  key_t        round_key;

  assign load = (st == IDLE) && start && !done;  // Start ignored while busy
  assign step = (st == RUN);
  assign last = (cnt == 4'(rounds - 1));
  assign busy = (st != IDLE) || done;

  always_comb begin
    st_nxt = st;
    case (st)
      IDLE:    if (load) st_nxt = RUN;
      RUN:     if (last) st_nxt = FINAL;
      FINAL:   st_nxt = IDLE;
      default: st_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      st   <= IDLE;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      st   <= st_nxt;
      done <= (st == FINAL);
      if (load) begin
        cnt <= '0;
      end else if (step) begin
        cnt <= cnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (st == FINAL) begin
      ciphertext <= state ^ round_key;  // Final whitening
    end
  end

  round_datapath u_round_datapath (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .step      (step),
    .plaintext (plaintext),
    .round_key (round_key),
    .state     (state)
  );

  key_schedule #(
    .rounds (rounds)
  ) u_key_schedule (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .step      (step),
    .key       (key),
    .round_key (round_key)
  );

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!arst_n)
    done |=> !done
  );

  a_busy_after_done: assert property (
    @(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> $past(done)
  );

endmodule

// File: source/key_schedule.sv
module key_schedule
  import cipher_pkg::*;
#(
  parameter int rounds = 6
) (
  input  logic clk,
  input  logic arst_n,
  input  logic load,
  input  logic step,
  input  key_t key,
  output key_t round_key
);

  logic [4:0] ridx;
  key_t       rot;
  lane_t      sub;

  if (rounds < 2 || rounds > 15) begin : g_bad_rounds
    $error("key_schedule: rounds must be 2 to 15");
  end

  assign rot = rot_lane(round_key);

  sbox6 u_sbox6 (
    .in  (rot[5:0]),
    .out (sub)
  );

  always_ff @(posedge clk) begin
    if (load) begin
      round_key <= key;
    end else if (step) begin
      round_key <= {rot[23:6], add_rc(sub, ridx)};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ridx <= '0;
    end else if (load) begin
      ridx <= '0;
    end else if (step) begin
      ridx <= ridx + 5'd1;
    end
  end

  a_ridx_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    ridx <= 5'(rounds)
  );

endmodule

// File: source/round_datapath.sv
module round_datapath
  import cipher_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   load,
  input  logic   step,
  input  block_t plaintext,
  input  key_t   round_key,
  output block_t state
);

  block_t mixed;
  block_t subst;

  assign mixed = state ^ round_key;  // Key addition

  for (genvar g = 0; g < 4; g++) begin : g_lane
    sbox6 u_sbox6 (
      .in  (mixed[6*g +: 6]),
      .out (subst[6*g +: 6])
    );
  end

  always_ff @(posedge clk) begin
    if (load) begin
      state <= plaintext;
    end else if (step) begin
      state <= perm_bits(subst);
    end
  end

  // The controller never loads mid-run
  a_no_load_step: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(load && step)
  );

endmodule

// File: source/sbox6.sv
module sbox6
  import gf_pkg::*;
  import cipher_pkg::*;
(
  input  lane_t in,
  output lane_t out
);

  gf64_t z;
  gf64_t w;
  gf4_t  x0;
  gf4_t  x1;
  gf4_t  x2;
  gf4_t  y0;
  gf4_t  y1;
  gf4_t  y2;
  gf4_t  c01;
  gf4_t  c02;
  gf4_t  c10;
  gf4_t  c12;
  gf4_t  c20;
  gf4_t  c21;
  gf4_t  q01;
  gf4_t  q02;
  gf4_t  q12;
  gf4_t  m01;
  gf4_t  m02;
  gf4_t  m12;
  gf4_t  t0;
  gf4_t  t1;
  gf4_t  t2;
  lane_t p;
  logic  aff;

  assign z  = gf_iso(in);        // Into GF(4)^3
  assign x0 = z[0];
  assign x1 = z[1];
  assign x2 = z[2];

  assign y0 = gf4_sq(x0);
  assign y1 = gf4_sq(x1);
  assign y2 = gf4_sq(x2);

  // Cube-scaled cross terms
  assign c01 = gf4_scale(x0, x1);
  assign c02 = gf4_scale(x0, x2);
  assign c10 = gf4_scale(x1, x0);
  assign c12 = gf4_scale(x1, x2);
  assign c20 = gf4_scale(x2, x0);
  assign c21 = gf4_scale(x2, x1);

  assign q01 = gf4_mul(y0, y1);  // Products of squares
  assign q02 = gf4_mul(y0, y2);
  assign q12 = gf4_mul(y1, y2);

  assign m01 = gf4_mul(x0, x1);
  assign m02 = gf4_mul(x0, x2);
  assign m12 = gf4_mul(x1, x2);

  assign t0 = gf4_mul(y0, m12);  // Degree-four terms
  assign t1 = gf4_mul(y1, m02);
  assign t2 = gf4_mul(y2, m01);

  always_comb begin
    w[0] = x0 ^ x1 ^ c10 ^ c12 ^ c20 ^ q01 ^ q02 ^ t0 ^ t2;
    w[1] = x1 ^ x2 ^ c01 ^ c20 ^ c21 ^ q01 ^ q12 ^ t0 ^ t1;
    w[2] = x0 ^ x2 ^ c01 ^ c02 ^ c12 ^ q02 ^ q12 ^ t1 ^ t2;
  end

  assign p   = gf_iso_inv(w);
  assign aff = in[2] ^ in[4];    // Affine correction bit
  assign out = p ^ {6{aff}};

endmodule

// File: source/cipher_pkg.sv
package cipher_pkg;
  import gf_pkg::*;

  typedef logic [23:0] block_t;  // Four lanes, lane 0 low
  typedef logic [23:0] key_t;
  typedef logic [5:0]  lane_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINAL
  } core_state_e;

  function automatic block_t perm_bits(block_t b);
    block_t r;
    for (int i = 0; i < 24; i++) begin
      r[6*(i%4) + i/4] = b[i];   // Spread each lane over all four
    end
    return r;
  endfunction

  function automatic key_t rot_lane(key_t k);
    return {k[17:0], k[23:18]};  // Left by one lane
  endfunction

  function automatic lane_t add_rc(lane_t l, logic [4:0] idx);
    return l ^ {1'b0, idx};
  endfunction

  function automatic key_t next_round_key(key_t k, logic [4:0] idx);
    key_t r;
    r      = rot_lane(k);
    r[5:0] = add_rc(sbox_ref(r[5:0]), idx);
    return r;
  endfunction

endpackage

// File: source/gf_pkg.sv
package gf_pkg;

  typedef logic [1:0] gf4_t;     // Normal basis over GF(2)
  typedef gf4_t [2:0] gf64_t;    // Limb 0 in low bits

  function automatic gf4_t gf4_sq(gf4_t a);
    return {a[0], a[1]};         // Frobenius is a bit swap
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // a^3 is one for any nonzero a, so this gates b
  function automatic gf4_t gf4_scale(gf4_t a, gf4_t b);
    return (a[0] | a[1]) ? b : 2'b00;
  endfunction

  function automatic gf64_t gf_iso(logic [5:0] a);
    logic [5:0] b;
    b[0] = a[0] ^ a[1];
    b[1] = a[0] ^ a[2] ^ a[4] ^ a[5];
    b[2] = a[0] ^ a[4] ^ a[5];
    b[3] = a[0] ^ a[5];
    b[4] = a[0] ^ a[3];
    b[5] = a[0] ^ a[1] ^ a[2] ^ a[5];
    return b;
  endfunction

  function automatic logic [5:0] gf_iso_inv(gf64_t w);
    logic [5:0] a;
    logic [5:0] b;
    a    = w;
    b[0] = a[1] ^ a[3];
    b[1] = a[1] ^ a[3] ^ a[4] ^ a[5];
    b[2] = a[5];
    b[3] = a[0] ^ a[1] ^ a[3];
    b[4] = a[2] ^ a[4];
    b[5] = a[0] ^ a[1] ^ a[3] ^ a[4];
    return b;
  endfunction

  function automatic gf64_t gf64_pow13(gf64_t x);
    gf4_t  y0, y1, y2;
    gf64_t r;
    y0   = gf4_sq(x[0]);
    y1   = gf4_sq(x[1]);
    y2   = gf4_sq(x[2]);
    r[0] = x[0] ^ x[1] ^ gf4_scale(x[1], x[0]) ^ gf4_scale(x[1], x[2])
         ^ gf4_scale(x[2], x[0]) ^ gf4_mul(y0, y1) ^ gf4_mul(y0, y2)
         ^ gf4_mul(y0, gf4_mul(x[1], x[2])) ^ gf4_mul(y2, gf4_mul(x[0], x[1]));
    r[1] = x[1] ^ x[2] ^ gf4_scale(x[0], x[1]) ^ gf4_scale(x[2], x[0])
         ^ gf4_scale(x[2], x[1]) ^ gf4_mul(y0, y1) ^ gf4_mul(y1, y2)
         ^ gf4_mul(y0, gf4_mul(x[1], x[2])) ^ gf4_mul(y1, gf4_mul(x[0], x[2]));
    r[2] = x[0] ^ x[2] ^ gf4_scale(x[0], x[1]) ^ gf4_scale(x[0], x[2])
         ^ gf4_scale(x[1], x[2]) ^ gf4_mul(y0, y2) ^ gf4_mul(y1, y2)
         ^ gf4_mul(y1, gf4_mul(x[0], x[2])) ^ gf4_mul(y2, gf4_mul(x[0], x[1]));
    return r;
  endfunction

  function automatic logic [5:0] sbox_ref(logic [5:0] x);
    return gf_iso_inv(gf64_pow13(gf_iso(x))) ^ {6{x[2] ^ x[4]}};
  endfunction

endpackage
